//--- csi_out_stage.sv
`default_nettype none

module csi_out_stage (
   input  logic                        mep_clk,
   input  logic                        rst_n,
   csi_pkt_if.snk                      beat,
   input  logic                        pkt_keep,
   input  logic                        tdi_en,
   output logic                        out_header_en,
   output logic                        out_data_en,
   output logic                        out_pkt_crc_en,
   output pkt_filter_pkg::data_type_t  out_data_type,
   output pkt_filter_pkg::vc_t         out_virtual_channel,
   output pkt_filter_pkg::word_count_t out_word_count,
   output pkt_filter_pkg::data_t       out_csi_data,
   output pkt_filter_pkg::byte_en_t    out_byte_en,
   output pkt_filter_pkg::crc_t        out_pkt_crc,
   output logic                        out_tunnel_mode_en
);

   logic beat_pass;   // Tunnel bypass or filter keep

   assign beat_pass = tdi_en | pkt_keep;

   // Strobes
   always_ff @(posedge mep_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_header_en      <= 1'b0;
         out_data_en        <= 1'b0;
         out_pkt_crc_en     <= 1'b0;
         out_tunnel_mode_en <= 1'b0;
      end else begin
         out_header_en      <= beat.header_en  & beat_pass;
         out_data_en        <= beat.data_en    & beat_pass;
         out_pkt_crc_en     <= beat.pkt_crc_en & beat_pass;
         out_tunnel_mode_en <= tdi_en & beat.tunnel_mode_en;   // Low when filtering
      end
   end

   // Fields follow every beat, qualified only by the strobes
   always_ff @(posedge mep_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_data_type       <= '0;
         out_virtual_channel <= '0;
         out_word_count      <= '0;
         out_csi_data        <= '0;
         out_byte_en         <= '0;
         out_pkt_crc         <= '0;
      end else begin
         out_data_type       <= beat.data_type;
         out_virtual_channel <= beat.virtual_channel;
         out_word_count      <= beat.word_count;
         out_csi_data        <= beat.csi_data;
         out_byte_en         <= beat.byte_en;
         out_pkt_crc         <= beat.pkt_crc;
      end
   end

endmodule

`default_nettype wire

//--- csi_pkt_if.sv
`default_nettype none

interface csi_pkt_if;

   logic                        header_en;
   logic                        data_en;
   logic                        pkt_crc_en;
   pkt_filter_pkg::data_type_t  data_type;
   pkt_filter_pkg::vc_t         virtual_channel;
   pkt_filter_pkg::word_count_t word_count;
   pkt_filter_pkg::data_t       csi_data;
   pkt_filter_pkg::byte_en_t    byte_en;
   pkt_filter_pkg::crc_t        pkt_crc;
   logic                        tunnel_mode_en;   // Sampled with the header

   modport src (
      output header_en, data_en, pkt_crc_en,
      output data_type, virtual_channel, word_count,
      output csi_data, byte_en,
      output pkt_crc, tunnel_mode_en
   );

   modport snk (
      input header_en, data_en, pkt_crc_en,
      input data_type, virtual_channel, word_count,
      input csi_data, byte_en,
      input pkt_crc, tunnel_mode_en
   );

endinterface

`default_nettype wire

//--- idi_tunnel_mode_ctrl.sv
`default_nettype none

module idi_tunnel_mode_ctrl (
   input  logic   mep_clk,
   input  logic   rst_n,
   csi_pkt_if.snk beat,
   input  logic   reg_mep_tdi_en,
   input  logic   reg_mep_tdi_en_force,
   output logic   tdi_en
);

   logic tdi_flag;   // Tunnel request from the last header
   logic pkt_tdi;

   always_ff @(posedge mep_clk or negedge rst_n) begin
      if (!rst_n) begin
         tdi_flag <= 1'b0;
      end else if (beat.header_en) begin
         tdi_flag <= beat.tunnel_mode_en;
      end
   end

   assign pkt_tdi = beat.header_en ? beat.tunnel_mode_en : tdi_flag;

   always_comb begin
      if (reg_mep_tdi_en_force) begin
         tdi_en = reg_mep_tdi_en;   // Register override for every beat
      end else begin
         tdi_en = pkt_tdi;
      end
   end

endmodule

`default_nettype wire

//--- pkt_drop_match.sv
`default_nettype none

module pkt_drop_match (
   input  pkt_filter_pkg::data_type_t data_type,
   input  pkt_filter_pkg::vc_t        virtual_channel,
   input  pkt_filter_pkg::dt_slot_t   reg_mem_dt1_selz,
   input  pkt_filter_pkg::dt_slot_t   reg_mem_dt2_selz,
   input  pkt_filter_pkg::dt_slot_t   reg_mem_dt7_selz,
   input  pkt_filter_pkg::dt_slot_t   reg_mem_dt8_selz,
   input  pkt_filter_pkg::dt_bound_t  reg_mem_dt3_selz,
   input  pkt_filter_pkg::dt_bound_t  reg_mem_dt4_selz,
   input  logic                       reg_mem_dt3_selz_en,
   input  logic                       reg_mem_dt4_selz_en,
   input  pkt_filter_pkg::vc_mask_t   reg_vc_selz_l,
   input  pkt_filter_pkg::vc_mask_t   reg_vc_selz_h,
   output logic                       drop_hit
);

   logic                              exact_hit;
   logic                              above_lo;
   logic                              below_hi;
   logic                              range_hit;
   logic                              vc_hit;
   logic [pkt_filter_pkg::NUM_VC-1:0] vc_mask;

   function automatic logic slot_hit(input pkt_filter_pkg::dt_slot_t   slot,
                                     input pkt_filter_pkg::data_type_t dt);
      return slot[pkt_filter_pkg::SLOT_EN_BIT] &&
             (slot[pkt_filter_pkg::DT_W-1:0] == dt);
   endfunction

   assign exact_hit = slot_hit(reg_mem_dt1_selz, data_type) |
                      slot_hit(reg_mem_dt2_selz, data_type) |
                      slot_hit(reg_mem_dt7_selz, data_type) |
                      slot_hit(reg_mem_dt8_selz, data_type);

   assign above_lo = (data_type >= reg_mem_dt3_selz);
   assign below_hi = (data_type <= reg_mem_dt4_selz);

   always_comb begin
      case ({reg_mem_dt3_selz_en, reg_mem_dt4_selz_en})
         2'b11:   range_hit = above_lo && below_hi;   // Inclusive window
         2'b10:   range_hit = above_lo;
         2'b01:   range_hit = below_hi;
         default: range_hit = 1'b0;
      endcase
   end

   assign vc_mask = {reg_vc_selz_h, reg_vc_selz_l};   // VC 15 down to VC 0
   assign vc_hit  = vc_mask[virtual_channel];

   assign drop_hit = exact_hit | range_hit | vc_hit;

endmodule

`default_nettype wire

//--- pkt_filter_lane.sv
`default_nettype none

module pkt_filter_lane (
   input  logic                      mep_clk,
   input  logic                      rst_n,
   csi_pkt_if.snk                    beat,
   input  pkt_filter_pkg::dt_slot_t  reg_mem_dt1_selz,
   input  pkt_filter_pkg::dt_slot_t  reg_mem_dt2_selz,
   input  pkt_filter_pkg::dt_slot_t  reg_mem_dt7_selz,
   input  pkt_filter_pkg::dt_slot_t  reg_mem_dt8_selz,
   input  pkt_filter_pkg::dt_bound_t reg_mem_dt3_selz,
   input  pkt_filter_pkg::dt_bound_t reg_mem_dt4_selz,
   input  logic                      reg_mem_dt3_selz_en,
   input  logic                      reg_mem_dt4_selz_en,
   input  pkt_filter_pkg::vc_mask_t  reg_vc_selz_l,
   input  pkt_filter_pkg::vc_mask_t  reg_vc_selz_h,
   output logic                      pkt_keep
);

   logic drop_hit;
   logic drop_flag;   // Decision of the packet in flight

   pkt_drop_match u_drop_match (
      .data_type           (beat.data_type),
      .virtual_channel     (beat.virtual_channel),
      .reg_mem_dt1_selz    (reg_mem_dt1_selz),
      .reg_mem_dt2_selz    (reg_mem_dt2_selz),
      .reg_mem_dt7_selz    (reg_mem_dt7_selz),
      .reg_mem_dt8_selz    (reg_mem_dt8_selz),
      .reg_mem_dt3_selz    (reg_mem_dt3_selz),
      .reg_mem_dt4_selz    (reg_mem_dt4_selz),
      .reg_mem_dt3_selz_en (reg_mem_dt3_selz_en),
      .reg_mem_dt4_selz_en (reg_mem_dt4_selz_en),
      .reg_vc_selz_l       (reg_vc_selz_l),
      .reg_vc_selz_h       (reg_vc_selz_h),
      .drop_hit            (drop_hit)
   );

   always_ff @(posedge mep_clk or negedge rst_n) begin
      if (!rst_n) begin
         drop_flag <= 1'b0;
      end else if (beat.header_en) begin
         drop_flag <= drop_hit;   // Held until the next header
      end
   end

   // Header uses the live match, data and CRC beats reuse the stored one
   assign pkt_keep = beat.header_en ? ~drop_hit : ~drop_flag;

endmodule

`default_nettype wire

//--- pkt_filter_pkg.sv
`default_nettype none

package pkt_filter_pkg;

   localparam int DATA_W      = 64;
   localparam int BYTE_EN_W   = 3;
   localparam int DT_W        = 6;
   localparam int VC_W        = 4;
   localparam int WC_W        = 16;
   localparam int CRC_W       = 32;
   localparam int VC_MASK_W   = 8;
   localparam int NUM_VC      = 16;        // Low and high mask halves together
   localparam int SLOT_EN_BIT = DT_W;      // Enable sits above the type field

   // Payload and header fields of one beat
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [BYTE_EN_W-1:0] byte_en_t;    // Valid bytes in the last beat
   typedef logic [DT_W-1:0]      data_type_t;
   typedef logic [VC_W-1:0]      vc_t;
   typedef logic [WC_W-1:0]      word_count_t;
   typedef logic [CRC_W-1:0]     crc_t;

   // Filter configuration registers
   typedef logic [DT_W:0]        dt_slot_t;    // Enable plus exact type
   typedef logic [DT_W-1:0]      dt_bound_t;   // Range bound
   typedef logic [VC_MASK_W-1:0] vc_mask_t;    // Half of the VC drop mask

endpackage

`default_nettype wire

//--- pkt_filter_top.sv
`default_nettype none

module pkt_filter_top (
   input  logic                        mep_clk,
   input  logic                        rst_n,
   // Input beat
   input  logic                        in_header_en,
   input  logic                        in_data_en,
   input  logic                        in_pkt_crc_en,
   input  pkt_filter_pkg::data_type_t  in_data_type,
   input  pkt_filter_pkg::vc_t         in_virtual_channel,
   input  pkt_filter_pkg::word_count_t in_word_count,
   input  pkt_filter_pkg::data_t       in_csi_data,
   input  pkt_filter_pkg::byte_en_t    in_byte_en,
   input  pkt_filter_pkg::crc_t        in_pkt_crc,
   input  logic                        in_tunnel_mode_en,
   // Filter registers
   input  pkt_filter_pkg::dt_slot_t    reg_mem_dt1_selz,
   input  pkt_filter_pkg::dt_slot_t    reg_mem_dt2_selz,
   input  pkt_filter_pkg::dt_slot_t    reg_mem_dt7_selz,
   input  pkt_filter_pkg::dt_slot_t    reg_mem_dt8_selz,
   input  pkt_filter_pkg::dt_bound_t   reg_mem_dt3_selz,
   input  pkt_filter_pkg::dt_bound_t   reg_mem_dt4_selz,
   input  logic                        reg_mem_dt3_selz_en,
   input  logic                        reg_mem_dt4_selz_en,
   input  pkt_filter_pkg::vc_mask_t    reg_vc_selz_l,
   input  pkt_filter_pkg::vc_mask_t    reg_vc_selz_h,
   input  logic                        reg_mep_tdi_en,
   input  logic                        reg_mep_tdi_en_force,
   // Output beat
   output logic                        out_header_en,
   output logic                        out_data_en,
   output logic                        out_pkt_crc_en,
   output pkt_filter_pkg::data_type_t  out_data_type,
   output pkt_filter_pkg::vc_t         out_virtual_channel,
   output pkt_filter_pkg::word_count_t out_word_count,
   output pkt_filter_pkg::data_t       out_csi_data,
   output pkt_filter_pkg::byte_en_t    out_byte_en,
   output pkt_filter_pkg::crc_t        out_pkt_crc,
   output logic                        out_tunnel_mode_en
);

   logic pkt_keep;
   logic tdi_en;

   csi_pkt_if in_beat ();

   assign in_beat.header_en       = in_header_en;
   assign in_beat.data_en         = in_data_en;
   assign in_beat.pkt_crc_en      = in_pkt_crc_en;
   assign in_beat.data_type       = in_data_type;
   assign in_beat.virtual_channel = in_virtual_channel;
   assign in_beat.word_count      = in_word_count;
   assign in_beat.csi_data        = in_csi_data;
   assign in_beat.byte_en         = in_byte_en;
   assign in_beat.pkt_crc         = in_pkt_crc;
   assign in_beat.tunnel_mode_en  = in_tunnel_mode_en;

   pkt_filter_lane u_filter_lane (
      .mep_clk             (mep_clk),
      .rst_n               (rst_n),
      .beat                (in_beat),
      .reg_mem_dt1_selz    (reg_mem_dt1_selz),
      .reg_mem_dt2_selz    (reg_mem_dt2_selz),
      .reg_mem_dt7_selz    (reg_mem_dt7_selz),
      .reg_mem_dt8_selz    (reg_mem_dt8_selz),
      .reg_mem_dt3_selz    (reg_mem_dt3_selz),
      .reg_mem_dt4_selz    (reg_mem_dt4_selz),
      .reg_mem_dt3_selz_en (reg_mem_dt3_selz_en),
      .reg_mem_dt4_selz_en (reg_mem_dt4_selz_en),
      .reg_vc_selz_l       (reg_vc_selz_l),
      .reg_vc_selz_h       (reg_vc_selz_h),
      .pkt_keep            (pkt_keep)
   );

   idi_tunnel_mode_ctrl u_tunnel_ctrl (
      .mep_clk              (mep_clk),
      .rst_n                (rst_n),
      .beat                 (in_beat),
      .reg_mep_tdi_en       (reg_mep_tdi_en),
      .reg_mep_tdi_en_force (reg_mep_tdi_en_force),
      .tdi_en               (tdi_en)
   );

   csi_out_stage u_out_stage (
      .mep_clk             (mep_clk),
      .rst_n               (rst_n),
      .beat                (in_beat),
      .pkt_keep            (pkt_keep),
      .tdi_en              (tdi_en),
      .out_header_en       (out_header_en),
      .out_data_en         (out_data_en),
      .out_pkt_crc_en      (out_pkt_crc_en),
      .out_data_type       (out_data_type),
      .out_virtual_channel (out_virtual_channel),
      .out_word_count      (out_word_count),
      .out_csi_data        (out_csi_data),
      .out_byte_en         (out_byte_en),
      .out_pkt_crc         (out_pkt_crc),
      .out_tunnel_mode_en  (out_tunnel_mode_en)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the packet filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_pkt_filter -o tb_pkt_filter
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_pkt_filter)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^STATUS: PASS$'; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sources.f
pkt_filter_pkg.sv
csi_pkt_if.sv
pkt_drop_match.sv
pkt_filter_lane.sv
idi_tunnel_mode_ctrl.sv
csi_out_stage.sv
pkt_filter_top.sv
tb_pkt_filter.sv

//--- tb_pkt_filter.sv
`default_nettype none

module tb_pkt_filter;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 3;
   localparam int SEED          = 32'h22cc_706a;
   localparam int MAX_WC        = 40;                  // Five data beats at most
   localparam int PKT_MAX_BEATS = (MAX_WC + 7) / 8 + 2;
   localparam int TEST_PKTS     = 12 + 13 + 11 + 16 + 8;
   localparam int GAP_CYCLES    = 3;
   localparam int NUM_TESTS     = 6;
   localparam int WATCHDOG_NS   = CLK_PERIOD * (RESET_CYCLES + TEST_PKTS * PKT_MAX_BEATS +
                                                NUM_TESTS * GAP_CYCLES + 60);
   localparam int FIELDS_W      = pkt_filter_pkg::DT_W + pkt_filter_pkg::VC_W +
                                  pkt_filter_pkg::WC_W + pkt_filter_pkg::DATA_W +
                                  pkt_filter_pkg::BYTE_EN_W + pkt_filter_pkg::CRC_W;

   logic                        mep_clk;
   logic                        rst_n;
   logic                        in_header_en;
   logic                        in_data_en;
   logic                        in_pkt_crc_en;
   pkt_filter_pkg::data_type_t  in_data_type;
   pkt_filter_pkg::vc_t         in_virtual_channel;
   pkt_filter_pkg::word_count_t in_word_count;
   pkt_filter_pkg::data_t       in_csi_data;
   pkt_filter_pkg::byte_en_t    in_byte_en;
   pkt_filter_pkg::crc_t        in_pkt_crc;
   logic                        in_tunnel_mode_en;
   pkt_filter_pkg::dt_slot_t    reg_mem_dt1_selz;
   pkt_filter_pkg::dt_slot_t    reg_mem_dt2_selz;
   pkt_filter_pkg::dt_slot_t    reg_mem_dt7_selz;
   pkt_filter_pkg::dt_slot_t    reg_mem_dt8_selz;
   pkt_filter_pkg::dt_bound_t   reg_mem_dt3_selz;
   pkt_filter_pkg::dt_bound_t   reg_mem_dt4_selz;
   logic                        reg_mem_dt3_selz_en;
   logic                        reg_mem_dt4_selz_en;
   pkt_filter_pkg::vc_mask_t    reg_vc_selz_l;
   pkt_filter_pkg::vc_mask_t    reg_vc_selz_h;
   logic                        reg_mep_tdi_en;
   logic                        reg_mep_tdi_en_force;
   logic                        out_header_en;
   logic                        out_data_en;
   logic                        out_pkt_crc_en;
   pkt_filter_pkg::data_type_t  out_data_type;
   pkt_filter_pkg::vc_t         out_virtual_channel;
   pkt_filter_pkg::word_count_t out_word_count;
   pkt_filter_pkg::data_t       out_csi_data;
   pkt_filter_pkg::byte_en_t    out_byte_en;
   pkt_filter_pkg::crc_t        out_pkt_crc;
   logic                        out_tunnel_mode_en;

   logic                 ref_drop;                    // Model state of the packet in flight
   logic                 ref_tdi;
   logic [3:0]           exp_en;
   logic [3:0]           chk_en;
   logic [3:0]           act_en;
   logic [FIELDS_W-1:0]  exp_fields;
   logic [FIELDS_W-1:0]  chk_fields;
   logic [FIELDS_W-1:0]  act_fields;
   int                   err_count = 0;
   int                   test_err_start;
   int                   tests_run;
   int                   tests_failed;
   int                   pkt_count;
   int                   drops_seen;
   string                cur_test;
   pkt_filter_pkg::data_type_t exact_types [4] = '{6'h12, 6'h1E, 6'h2A, 6'h30};

   pkt_filter_top UUT (.*);

   initial mep_clk = 1'b0;
   always #(CLK_PERIOD / 2) mep_clk = ~mep_clk;

   assign act_en     = {out_header_en, out_data_en, out_pkt_crc_en, out_tunnel_mode_en};
   assign act_fields = {out_data_type, out_virtual_channel, out_word_count,
                        out_csi_data, out_byte_en, out_pkt_crc};

   // Expected beat moves one stage with the DUT register
   always @(posedge mep_clk) begin
      chk_en     <= exp_en;
      chk_fields <= exp_fields;
   end

   task automatic report_mismatch(input string what, input logic [127:0] exp,
                                  input logic [127:0] act);
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
      err_count++;
   endtask

   enables_match: assert property (@(negedge mep_clk) disable iff (!rst_n)
         act_en == chk_en)
      else report_mismatch("enables", 128'(chk_en), 128'(act_en));

   fields_match: assert property (@(negedge mep_clk) disable iff (!rst_n)
         act_fields == chk_fields)
      else report_mismatch("fields", 128'(chk_fields), 128'(act_fields));

   reset_clears: assert property (@(negedge mep_clk)
         !rst_n |-> (act_en == '0 && act_fields == '0))
      else begin
         $display("outputs not cleared while reset is asserted");
         err_count++;
      end

   // Drop rule from the register description
   function automatic logic drop_rule(input pkt_filter_pkg::data_type_t dt,
                                      input pkt_filter_pkg::vc_t vc);
      pkt_filter_pkg::dt_slot_t          slots [4];
      logic                              vc_drop;
      logic                              hit;
      slots[0] = reg_mem_dt1_selz;
      slots[1] = reg_mem_dt2_selz;
      slots[2] = reg_mem_dt7_selz;
      slots[3] = reg_mem_dt8_selz;
      hit = 1'b0;
      foreach (slots[i]) begin
         if (slots[i][pkt_filter_pkg::DT_W] && slots[i][pkt_filter_pkg::DT_W-1:0] == dt) begin
            hit = 1'b1;
         end
      end
      if (reg_mem_dt3_selz_en && reg_mem_dt4_selz_en) begin
         if (dt >= reg_mem_dt3_selz && dt <= reg_mem_dt4_selz) begin
            hit = 1'b1;
         end
      end else if (reg_mem_dt3_selz_en && dt >= reg_mem_dt3_selz) begin
         hit = 1'b1;
      end else if (reg_mem_dt4_selz_en && dt <= reg_mem_dt4_selz) begin
         hit = 1'b1;
      end
      if (vc < pkt_filter_pkg::VC_MASK_W) begin
         vc_drop = reg_vc_selz_l[vc[2:0]];                // VC 0 to 7
      end else begin
         vc_drop = reg_vc_selz_h[vc[2:0]];                // VC 8 to 15
      end
      if (vc_drop) begin
         hit = 1'b1;
      end
      return hit;
   endfunction

   // Expected output for the beat just driven
   task automatic predict();
      logic tun;
      logic keep;
      if (in_header_en) begin
         ref_drop = drop_rule(in_data_type, in_virtual_channel);
         ref_tdi  = in_tunnel_mode_en;
      end
      tun  = reg_mep_tdi_en_force ? reg_mep_tdi_en : ref_tdi;
      keep = tun || !ref_drop;
      if (in_header_en && !keep) begin
         drops_seen++;
      end
      exp_en     = {in_header_en & keep, in_data_en & keep, in_pkt_crc_en & keep,
                    tun & in_tunnel_mode_en};
      exp_fields = {in_data_type, in_virtual_channel, in_word_count,
                    in_csi_data, in_byte_en, in_pkt_crc};
   endtask

   task automatic clear_inputs();
      in_header_en       = 1'b0;
      in_data_en         = 1'b0;
      in_pkt_crc_en      = 1'b0;
      in_data_type       = '0;
      in_virtual_channel = '0;
      in_word_count      = '0;
      in_csi_data        = '0;
      in_byte_en         = '0;
      in_pkt_crc         = '0;
      in_tunnel_mode_en  = 1'b0;
   endtask

   task automatic clear_config();
      reg_mem_dt1_selz     = '0;
      reg_mem_dt2_selz     = '0;
      reg_mem_dt7_selz     = '0;
      reg_mem_dt8_selz     = '0;
      reg_mem_dt3_selz     = '0;
      reg_mem_dt4_selz     = '0;
      reg_mem_dt3_selz_en  = 1'b0;
      reg_mem_dt4_selz_en  = 1'b0;
      reg_vc_selz_l        = '0;
      reg_vc_selz_h        = '0;
      reg_mep_tdi_en       = 1'b0;
      reg_mep_tdi_en_force = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge mep_clk);
         clear_inputs();
         predict();
      end
   endtask

   // Header, data beats from the word count, then CRC, back to back
   task automatic send_packet(input pkt_filter_pkg::data_type_t dt,
                              input pkt_filter_pkg::vc_t vc, input logic tun);
      int wc;
      int n_data;
      wc     = $urandom_range(0, MAX_WC);
      n_data = (wc + 7) / 8;
      @(negedge mep_clk);
      clear_inputs();
      in_header_en       = 1'b1;
      in_data_type       = dt;
      in_virtual_channel = vc;
      in_word_count      = pkt_filter_pkg::word_count_t'(wc);
      in_tunnel_mode_en  = tun;
      predict();
      for (int i = 0; i < n_data; i++) begin
         @(negedge mep_clk);
         clear_inputs();
         in_data_en        = 1'b1;
         in_csi_data       = {$urandom, $urandom};
         in_byte_en        = (i == n_data - 1) ? pkt_filter_pkg::byte_en_t'(wc) : '0;
         in_tunnel_mode_en = ~tun;                       // Only the header bit is latched
         predict();
      end
      @(negedge mep_clk);
      clear_inputs();
      in_pkt_crc_en     = 1'b1;
      in_pkt_crc        = $urandom;
      in_tunnel_mode_en = ~tun;
      predict();
      pkt_count++;
   endtask

   task automatic send_typed(input pkt_filter_pkg::data_type_t dt);
      send_packet(dt, pkt_filter_pkg::vc_t'($urandom), 1'b0);
   endtask

   task automatic begin_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
      pkt_count      = 0;
      drops_seen     = 0;
   endtask

   task automatic end_test();
      int errs;
      idle_cycles(GAP_CYCLES);                           // Drain the last beat
      errs = err_count - test_err_start;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %s done: %0d packets, %0d dropped, %0d errors",
               cur_test, pkt_count, drops_seen, errs);
      clear_config();
   endtask

   initial begin
      int vc_lo_bit;
      int vc_hi_bit;
      void'($urandom(SEED));
      tests_run    = 0;
      tests_failed = 0;
      ref_drop     = 1'b0;
      ref_tdi      = 1'b0;
      rst_n        = 1'b0;
      clear_config();
      clear_inputs();
      predict();
      repeat (RESET_CYCLES) @(posedge mep_clk);
      @(negedge mep_clk);
      rst_n = 1'b1;

      begin_test("reset");
      idle_cycles(4);                                    // No beat offered yet
      end_test();

      begin_test("pass_through");
      repeat (12) begin
         send_packet(pkt_filter_pkg::data_type_t'($urandom),
                     pkt_filter_pkg::vc_t'($urandom), 1'b0);
      end
      end_test();

      begin_test("exact_match");
      reg_mem_dt1_selz = {1'b1, exact_types[0]};
      reg_mem_dt2_selz = {1'b1, exact_types[1]};
      reg_mem_dt7_selz = {1'b1, exact_types[2]};
      reg_mem_dt8_selz = {1'b1, exact_types[3]};
      foreach (exact_types[i]) begin
         for (int d = -1; d <= 1; d++) begin
            send_typed(pkt_filter_pkg::data_type_t'(exact_types[i] + d));
         end
      end
      idle_cycles(1);
      reg_mem_dt1_selz[pkt_filter_pkg::SLOT_EN_BIT] = 1'b0;   // Type kept, slot disabled
      send_typed(exact_types[0]);
      end_test();

      begin_test("range");
      reg_mem_dt3_selz_en = 1'b1;                        // Lower bound only
      reg_mem_dt3_selz    = 6'h20;
      send_typed(6'h1F);
      send_typed(6'h20);
      send_typed(6'h3F);
      idle_cycles(1);
      reg_mem_dt3_selz_en = 1'b0;                        // Upper bound only
      reg_mem_dt4_selz_en = 1'b1;
      reg_mem_dt4_selz    = 6'h10;
      send_typed(6'h10);
      send_typed(6'h11);
      send_typed(6'h00);
      idle_cycles(1);
      reg_mem_dt3_selz_en = 1'b1;                        // Window 18 to 24
      reg_mem_dt3_selz    = 6'h18;
      reg_mem_dt4_selz    = 6'h24;
      send_typed(6'h17);
      send_typed(6'h18);
      send_typed(6'h1E);
      send_typed(6'h24);
      send_typed(6'h25);
      end_test();

      begin_test("vc_mask");
      vc_lo_bit     = $urandom_range(0, 7);
      vc_hi_bit     = $urandom_range(0, 7);
      reg_vc_selz_l = pkt_filter_pkg::vc_mask_t'(1 << vc_lo_bit);
      reg_vc_selz_h = pkt_filter_pkg::vc_mask_t'(1 << vc_hi_bit);
      for (int v = 0; v < pkt_filter_pkg::NUM_VC; v++) begin
         send_packet(pkt_filter_pkg::data_type_t'($urandom), pkt_filter_pkg::vc_t'(v), 1'b0);
      end
      end_test();

      begin_test("tunnel");
      reg_mem_dt1_selz     = {1'b1, 6'h2C};
      reg_mep_tdi_en_force = 1'b1;
      reg_mep_tdi_en       = 1'b1;
      repeat (4) begin
         send_packet(6'h2C, pkt_filter_pkg::vc_t'($urandom), 1'($urandom));
      end
      idle_cycles(1);
      reg_mep_tdi_en_force = 1'b0;                       // Follow the header bit again
      reg_mep_tdi_en       = 1'b0;
      send_packet(6'h2C, 4'h3, 1'b1);
      send_packet(6'h2C, 4'h3, 1'b0);
      send_packet(6'h2C, 4'h9, 1'b1);
      send_packet(6'h2C, 4'h9, 1'b0);
      end_test();

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests completed in %s", cur_test);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
